/* hw/board_pkg.sv */
package board_pkg;

  // ============================================================
  // GPIO pad ring
  // ============================================================
  localparam logic [5:0] GPIO_WIDTH = 6'd32;
  localparam int unsigned GPIO_SYNC_STAGES = 2;

  // ============================================================
  // External SRAM, two 16-bit chips forming one 32-bit word
  // ============================================================
  localparam int unsigned SRAM_ADDR_WIDTH = 22;
  localparam int unsigned SRAM_CHIP_WIDTH = 16;
  localparam int unsigned SRAM_WORD_WIDTH = 2 * SRAM_CHIP_WIDTH;

  // Strobe window length of one access
  localparam int unsigned SRAM_ACCESS_CYCLES = 3;
  localparam int unsigned SRAM_CNT_WIDTH = $clog2(SRAM_ACCESS_CYCLES + 1);
  localparam logic [SRAM_CNT_WIDTH-1:0] SRAM_CNT_LAST = SRAM_CNT_WIDTH'(SRAM_ACCESS_CYCLES);

  // Controller state encoding
  localparam logic [1:0] SRAM_ST_IDLE   = 2'd0;
  localparam logic [1:0] SRAM_ST_STROBE = 2'd1;
  localparam logic [1:0] SRAM_ST_ACK    = 2'd2;

  // Core word seen whole or as the two chip halves
  typedef union packed {
    logic [SRAM_WORD_WIDTH-1:0] word;
    struct packed {
      logic [SRAM_CHIP_WIDTH-1:0] hi;
      logic [SRAM_CHIP_WIDTH-1:0] lo;
    } half;
  } sram_word_u;

  // ============================================================
  // Reset sequencing
  // ============================================================
  localparam int unsigned RST_HOLD_CYCLES = 16;
  localparam int unsigned RST_CNT_WIDTH = $clog2(RST_HOLD_CYCLES);
  // Two edges of the hold are spent in the lock synchronizer
  localparam logic [RST_CNT_WIDTH-1:0] RST_CNT_LAST = RST_CNT_WIDTH'(RST_HOLD_CYCLES - 2);

endpackage

/* hw/board_reset_seq.sv */
`timescale 1ns/1ns

module board_reset_seq import board_pkg::*; (
  input  logic sysclk_i,
  input  logic arst_n_i,
  input  logic pll_locked_i,
  output logic periph_rst_n_o
);

  logic [1:0] lock_sync_q;
  logic       lock_ok;
  logic [RST_CNT_WIDTH-1:0] hold_cnt_q;
  logic       rst_n_q;

  // Raw lock term lets a lock drop take effect on the next edge
  assign lock_ok = pll_locked_i & lock_sync_q[1];

  // Lock indication into the clock domain
  always_ff @(posedge sysclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_sync_q <= 2'b00;
    end else begin
      lock_sync_q <= {lock_sync_q[0], pll_locked_i};
    end
  end

  // Hold counter, saturates at the release point
  always_ff @(posedge sysclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_cnt_q <= '0;
    end else if (!lock_ok) begin
      hold_cnt_q <= '0;
    end else if (hold_cnt_q != RST_CNT_LAST) begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge sysclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_n_q <= 1'b0;
    end else begin
      rst_n_q <= lock_ok && (hold_cnt_q == RST_CNT_LAST);
    end
  end

  assign periph_rst_n_o = rst_n_q;

endmodule

/* hw/gpio_pad_ring.sv */
`timescale 1ns/1ns

module gpio_pad_ring import board_pkg::*; (
  input  logic                  sysclk_i,
  input  logic                  rst_n_i,
  input  logic [GPIO_WIDTH-1:0] gpio_out_i,
  input  logic [GPIO_WIDTH-1:0] gpio_oe_i,
  input  logic [GPIO_WIDTH-1:0] gpio_ie_i,
  output logic [GPIO_WIDTH-1:0] gpio_in_o,
  inout  wire  [GPIO_WIDTH-1:0] gpio_io
);

  logic [GPIO_WIDTH-1:0] sync_q [GPIO_SYNC_STAGES];

  // ============================================================
  // Output drivers, one tri-state buffer per pad
  // ============================================================
  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad
    assign gpio_io[i] = gpio_oe_i[i] ? gpio_out_i[i] : 1'bz;
  end

  // ============================================================
  // Input synchronizer
  // ============================================================
  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < GPIO_SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= gpio_io;
      for (int s = 1; s < GPIO_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // Input enable acts after the synchronizer, so it takes effect at once
  assign gpio_in_o = sync_q[GPIO_SYNC_STAGES-1] & gpio_ie_i;

endmodule

/* hw/sram_ctrl.sv */
`timescale 1ns/1ns

module sram_ctrl import board_pkg::*; (
  input  logic                       sysclk_i,
  input  logic                       rst_n_i,

  // Core side, four-phase req/ack
  input  logic                       mem_req_i,
  input  logic                       mem_we_i,
  input  logic [SRAM_ADDR_WIDTH-1:0] mem_addr_i,
  input  logic [SRAM_WORD_WIDTH-1:0] mem_wdata_i,
  output logic                       mem_ack_o,
  output logic [SRAM_WORD_WIDTH-1:0] mem_rdata_o,

  // Chip side, strobes and address shared by both chips
  output logic                       sram_ce_n_o,
  output logic                       sram_oe_n_o,
  output logic                       sram_we_n_o,
  output logic [SRAM_ADDR_WIDTH-1:0] sram_addr_o,
  inout  wire  [SRAM_CHIP_WIDTH-1:0] sram0_dq_io,
  inout  wire  [SRAM_CHIP_WIDTH-1:0] sram1_dq_io
);

  logic [1:0]                state_q;
  logic [SRAM_CNT_WIDTH-1:0] cnt_q;
  logic                      ack_q;
  logic                      ce_n_q;
  logic                      oe_n_q;
  logic                      we_n_q;
  logic                      dq_oe_q;

  logic                       we_q;
  logic [SRAM_ADDR_WIDTH-1:0] addr_q;
  sram_word_u                 wdata_q;
  sram_word_u                 rd_word;
  logic [SRAM_WORD_WIDTH-1:0] rdata_q;

  logic accept;
  logic strobe_last;

  assign accept      = (state_q == SRAM_ST_IDLE) && mem_req_i;
  assign strobe_last = (state_q == SRAM_ST_STROBE) && (cnt_q == SRAM_CNT_LAST);

  // ============================================================
  // Handshake and strobe FSM
  // ============================================================
  // Edge 0 accepts and registers the request, edges 1..3 hold the
  // strobes low, edge 4 releases them and raises ack
  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SRAM_ST_IDLE;
      cnt_q   <= '0;
      ack_q   <= 1'b0;
      ce_n_q  <= 1'b1;
      oe_n_q  <= 1'b1;
      we_n_q  <= 1'b1;
      dq_oe_q <= 1'b0;
    end else begin
      case (state_q)
        SRAM_ST_IDLE: begin
          if (accept) begin
            state_q <= SRAM_ST_STROBE;
            cnt_q   <= '0;
          end
        end
        SRAM_ST_STROBE: begin
          if (strobe_last) begin
            state_q <= SRAM_ST_ACK;
            ack_q   <= 1'b1;
            ce_n_q  <= 1'b1;
            oe_n_q  <= 1'b1;
            we_n_q  <= 1'b1;
            dq_oe_q <= 1'b0;
          end else begin
            cnt_q   <= cnt_q + 1'b1;
            ce_n_q  <= 1'b0;
            oe_n_q  <= we_q;
            we_n_q  <= !we_q;
            dq_oe_q <= we_q;
          end
        end
        SRAM_ST_ACK: begin
          // Wait for the core to drop its request
          if (!mem_req_i) begin
            state_q <= SRAM_ST_IDLE;
            ack_q   <= 1'b0;
          end
        end
        default: begin
          state_q <= SRAM_ST_IDLE;
        end
      endcase
    end
  end

  // ============================================================
  // Request and read data capture
  // ============================================================
  always_ff @(posedge sysclk_i) begin
    if (accept) begin
      we_q         <= mem_we_i;
      addr_q       <= mem_addr_i;
      wdata_q.word <= mem_wdata_i;
    end
  end

  // Sampled on the last strobe cycle while OE is still low
  always_ff @(posedge sysclk_i) begin
    if (strobe_last && !we_q) begin
      rdata_q <= rd_word.word;
    end
  end

  // ============================================================
  // Data pad steering
  // ============================================================
  // Chip 0 carries the low half, chip 1 the high half
  assign sram0_dq_io = dq_oe_q ? wdata_q.half.lo : {SRAM_CHIP_WIDTH{1'bz}};
  assign sram1_dq_io = dq_oe_q ? wdata_q.half.hi : {SRAM_CHIP_WIDTH{1'bz}};

  always_comb begin
    rd_word.half.lo = sram0_dq_io;
    rd_word.half.hi = sram1_dq_io;
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;
  assign sram_ce_n_o = ce_n_q;
  assign sram_oe_n_o = oe_n_q;
  assign sram_we_n_o = we_n_q;
  assign sram_addr_o = addr_q;

endmodule

/* hw/board_top.sv */
`timescale 1ns/1ns

module board_top import board_pkg::*; (
  input  logic                       sysclk_i,
  input  logic                       arst_n_i,
  input  logic                       pll_locked_i,
  output logic                       periph_rst_n_o,

  // GPIO pads
  input  logic [GPIO_WIDTH-1:0]      gpio_out_i,
  input  logic [GPIO_WIDTH-1:0]      gpio_oe_i,
  input  logic [GPIO_WIDTH-1:0]      gpio_ie_i,
  output logic [GPIO_WIDTH-1:0]      gpio_in_o,
  inout  wire  [GPIO_WIDTH-1:0]      gpio_io,

  // Core memory port
  input  logic                       mem_req_i,
  input  logic                       mem_we_i,
  input  logic [SRAM_ADDR_WIDTH-1:0] mem_addr_i,
  input  logic [SRAM_WORD_WIDTH-1:0] mem_wdata_i,
  output logic                       mem_ack_o,
  output logic [SRAM_WORD_WIDTH-1:0] mem_rdata_o,

  // External SRAM chips, UB/LB tied low on the board
  output logic                       sram_ce_n_o,
  output logic                       sram_oe_n_o,
  output logic                       sram_we_n_o,
  output logic [SRAM_ADDR_WIDTH-1:0] sram_addr_o,
  inout  wire  [SRAM_CHIP_WIDTH-1:0] sram0_dq_io,
  inout  wire  [SRAM_CHIP_WIDTH-1:0] sram1_dq_io
);

  logic periph_rst_n;

  // ============================================================
  // Clock and reset
  // ============================================================
  board_reset_seq i_reset_seq (
    .sysclk_i       (sysclk_i),
    .arst_n_i       (arst_n_i),
    .pll_locked_i   (pll_locked_i),
    .periph_rst_n_o (periph_rst_n)
  );

  assign periph_rst_n_o = periph_rst_n;

  // ============================================================
  // GPIO pads
  // ============================================================
  gpio_pad_ring i_gpio_pad_ring (
    .sysclk_i   (sysclk_i),
    .rst_n_i    (periph_rst_n),
    .gpio_out_i (gpio_out_i),
    .gpio_oe_i  (gpio_oe_i),
    .gpio_ie_i  (gpio_ie_i),
    .gpio_in_o  (gpio_in_o),
    .gpio_io    (gpio_io)
  );

  // ============================================================
  // External SRAM
  // ============================================================
  sram_ctrl i_sram_ctrl (
    .sysclk_i    (sysclk_i),
    .rst_n_i     (periph_rst_n),
    .mem_req_i   (mem_req_i),
    .mem_we_i    (mem_we_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_ack_o   (mem_ack_o),
    .mem_rdata_o (mem_rdata_o),
    .sram_ce_n_o (sram_ce_n_o),
    .sram_oe_n_o (sram_oe_n_o),
    .sram_we_n_o (sram_we_n_o),
    .sram_addr_o (sram_addr_o),
    .sram0_dq_io (sram0_dq_io),
    .sram1_dq_io (sram1_dq_io)
  );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o
);

  localparam int unsigned HALF_PERIOD = 2;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

/* dv/sram_chip_model.sv */
`timescale 1ns/1ns

module sram_chip_model import board_pkg::*; (
  input  logic                       ce_n_i,
  input  logic                       oe_n_i,
  input  logic                       we_n_i,
  input  logic [SRAM_ADDR_WIDTH-1:0] addr_i,
  inout  wire  [SRAM_CHIP_WIDTH-1:0] dq_io
);

  // Small tagged store, low address bits pick the slot
  localparam int unsigned SLOT_BITS = 6;
  localparam int unsigned SLOTS = 1 << SLOT_BITS;

  logic [SRAM_CHIP_WIDTH-1:0] data_q  [SLOTS];
  logic [SRAM_ADDR_WIDTH-1:0] tag_q   [SLOTS];
  logic                       valid_q [SLOTS];
  logic [SRAM_CHIP_WIDTH-1:0] rd_data;

  // Unwritten or evicted locations read as X
  function automatic logic [SRAM_CHIP_WIDTH-1:0] peek(input logic [SRAM_ADDR_WIDTH-1:0] addr);
    logic [SLOT_BITS-1:0] slot;
    slot = addr[SLOT_BITS-1:0];
    if (valid_q[slot] && (tag_q[slot] == addr)) begin
      return data_q[slot];
    end
    return 'x;
  endfunction

  initial begin
    for (int i = 0; i < SLOTS; i++) begin
      valid_q[i] = 1'b0;
    end
  end

  // Data latched shortly after WE falls, inside the strobe window
  always @(negedge we_n_i) begin
    #1;
    if (!ce_n_i && !we_n_i) begin
      data_q[addr_i[SLOT_BITS-1:0]]  = dq_io;
      tag_q[addr_i[SLOT_BITS-1:0]]   = addr_i;
      valid_q[addr_i[SLOT_BITS-1:0]] = 1'b1;
    end
  end

  always @(addr_i or ce_n_i or oe_n_i or we_n_i) begin
    rd_data = peek(addr_i);
  end

  assign dq_io = (!ce_n_i && !oe_n_i && we_n_i) ? rd_data : {SRAM_CHIP_WIDTH{1'bz}};

endmodule

/* dv/board_tb.sv */
`timescale 1ns/1ns

module board_tb import board_pkg::*; ();

  localparam int NUM_VEC     = 8;
  localparam int RST_CYCLES  = 16;
  localparam int RST_TIMEOUT = 64;
  localparam int ACK_TIMEOUT = 32;

  typedef struct packed {
    logic [SRAM_ADDR_WIDTH-1:0] addr;
    logic [SRAM_WORD_WIDTH-1:0] wdata;
    logic [GPIO_WIDTH-1:0]      out, oe, ie, ie_clr, drive;
    logic [GPIO_WIDTH-1:0]      exp_pad, exp_in;
  } vec_t;

  logic                       clk;
  logic                       arst_n;
  logic                       pll_locked;
  logic                       periph_rst_n;
  logic [GPIO_WIDTH-1:0]      gpio_out, gpio_oe, gpio_ie, gpio_in, pad_drive;
  wire  [GPIO_WIDTH-1:0]      gpio_pad;
  logic                       mem_req, mem_we, mem_ack;
  logic [SRAM_ADDR_WIDTH-1:0] mem_addr, sram_addr;
  logic [SRAM_WORD_WIDTH-1:0] mem_wdata, mem_rdata;
  logic                       sram_ce_n, sram_oe_n, sram_we_n;
  wire  [SRAM_CHIP_WIDTH-1:0] sram0_dq, sram1_dq;

  vec_t        vec_tbl [NUM_VEC];
  logic [31:0] lfsr_q;
  int          chk_cnt;
  int          err_cnt;
  int          tmo_cnt;

  tb_clk_gen i_clk_gen (.clk_o(clk));

  board_top i_dut (
    .sysclk_i (clk), .arst_n_i (arst_n), .pll_locked_i (pll_locked),
    .periph_rst_n_o (periph_rst_n),
    .gpio_out_i (gpio_out), .gpio_oe_i (gpio_oe), .gpio_ie_i (gpio_ie),
    .gpio_in_o (gpio_in), .gpio_io (gpio_pad),
    .mem_req_i (mem_req), .mem_we_i (mem_we), .mem_addr_i (mem_addr),
    .mem_wdata_i (mem_wdata), .mem_ack_o (mem_ack), .mem_rdata_o (mem_rdata),
    .sram_ce_n_o (sram_ce_n), .sram_oe_n_o (sram_oe_n), .sram_we_n_o (sram_we_n),
    .sram_addr_o (sram_addr), .sram0_dq_io (sram0_dq), .sram1_dq_io (sram1_dq)
  );

  sram_chip_model i_sram0 (
    .ce_n_i (sram_ce_n), .oe_n_i (sram_oe_n), .we_n_i (sram_we_n),
    .addr_i (sram_addr), .dq_io (sram0_dq)
  );

  sram_chip_model i_sram1 (
    .ce_n_i (sram_ce_n), .oe_n_i (sram_oe_n), .we_n_i (sram_we_n),
    .addr_i (sram_addr), .dq_io (sram1_dq)
  );

  // Board drives only the pads the DUT leaves floating
  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad_drv
    assign gpio_pad[i] = gpio_oe[i] ? 1'bz : pad_drive[i];
  end

  // Taps of x^32 + x^22 + x^2 + x + 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic void fill_table();
    logic [31:0] tmp;
    for (int i = 0; i < NUM_VEC; i++) begin
      tmp = rand_bits(16);
      // Low bits from the index keep every address distinct
      vec_tbl[i].addr    = {tmp[15:0], 6'(i)};
      vec_tbl[i].wdata   = rand_bits(32);
      vec_tbl[i].out     = rand_bits(32);
      vec_tbl[i].oe      = rand_bits(32);
      vec_tbl[i].ie      = rand_bits(32);
      vec_tbl[i].ie_clr  = rand_bits(32);
      vec_tbl[i].drive   = rand_bits(32);
      vec_tbl[i].exp_pad = (vec_tbl[i].out & vec_tbl[i].oe) | (vec_tbl[i].drive & ~vec_tbl[i].oe);
      vec_tbl[i].exp_in  = vec_tbl[i].exp_pad & vec_tbl[i].ie;
    end
  endfunction

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("error %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // One four-phase access with strobe and handshake timing checked on the way
  task automatic mem_access(input logic we, input logic [SRAM_ADDR_WIDTH-1:0] addr,
                            input logic [SRAM_WORD_WIDTH-1:0] wdata,
                            output logic [SRAM_WORD_WIDTH-1:0] rdata);
    int n;
    @(negedge clk);
    mem_req   = 1'b1;
    mem_we    = we;
    mem_addr  = addr;
    mem_wdata = wdata;
    rdata     = 'x;
    n = 0;
    while (!mem_ack && (n < ACK_TIMEOUT)) begin
      @(negedge clk);
      n++;
      if (n == 1) begin
        compare("sram_ce_n_o", sram_ce_n, 1'b1);
      end else if (!mem_ack) begin
        compare("sram_ce_n_o", sram_ce_n, 1'b0);
        compare("sram_oe_n_o", sram_oe_n, we);
        compare("sram_we_n_o", sram_we_n, !we);
        compare("sram_addr_o", sram_addr, addr);
        if (we) begin
          compare("sram0_dq_io", sram0_dq, wdata[15:0]);
          compare("sram1_dq_io", sram1_dq, wdata[31:16]);
        end
      end
    end
    if (!mem_ack) begin
      tmo_cnt++;
      $display("timeout: memory acknowledge never arrived for address %h", addr);
      mem_req = 1'b0;
    end else begin
      compare("mem_ack_o latency", n - 1, SRAM_ACCESS_CYCLES + 1);
      rdata = mem_rdata;
      compare("sram_ce_n_o", sram_ce_n, 1'b1);
      compare("sram_oe_n_o", sram_oe_n, 1'b1);
      compare("sram_we_n_o", sram_we_n, 1'b1);
      compare("sram0_dq_io", sram0_dq, {SRAM_CHIP_WIDTH{1'bz}});
      compare("sram1_dq_io", sram1_dq, {SRAM_CHIP_WIDTH{1'bz}});
      // Request still high so no second access may start
      repeat (2) begin
        @(negedge clk);
        compare("mem_ack_o", mem_ack, 1'b1);
        compare("sram_ce_n_o", sram_ce_n, 1'b1);
      end
      mem_req = 1'b0;
      @(negedge clk);
      compare("mem_ack_o", mem_ack, 1'b0);
    end
  endtask

  initial begin
    logic [SRAM_WORD_WIDTH-1:0] rdata;
    logic [GPIO_WIDTH-1:0]      prev_pad;
    int                         n;
    arst_n     = 1'b0;
    pll_locked = 1'b0;
    gpio_out   = '0;
    gpio_oe    = '0;
    gpio_ie    = '1;
    mem_req    = 1'b0;
    mem_we     = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    chk_cnt    = 0;
    err_cnt    = 0;
    tmo_cnt    = 0;
    lfsr_q     = 32'd97578;
    pad_drive  = rand_bits(32);
    prev_pad   = pad_drive;
    fill_table();

    // ============================================================
    // Reset release
    // ============================================================
    repeat (RST_CYCLES) begin
      @(negedge clk);
      compare("periph_rst_n_o", periph_rst_n, 1'b0);
    end
    arst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      compare("periph_rst_n_o", periph_rst_n, 1'b0);
    end
    pll_locked = 1'b1;
    n = 0;
    while (!periph_rst_n && (n < RST_TIMEOUT)) begin
      @(negedge clk);
      n++;
    end
    if (!periph_rst_n) begin
      tmo_cnt++;
      $display("timeout: peripheral reset stayed asserted after PLL lock");
    end else begin
      // Sampling edge plus the hold
      compare("periph_rst_n_o release edge", n, RST_HOLD_CYCLES + 1);
      compare("mem_ack_o", mem_ack, 1'b0);
      compare("sram_ce_n_o", sram_ce_n, 1'b1);
      compare("sram_oe_n_o", sram_oe_n, 1'b1);
      compare("sram_we_n_o", sram_we_n, 1'b1);
      compare("gpio_in_o", gpio_in, '0);
    end

    // ============================================================
    // GPIO table and SRAM writes
    // ============================================================
    for (int i = 0; i < NUM_VEC; i++) begin
      @(negedge clk);
      gpio_out  = vec_tbl[i].out;
      gpio_oe   = vec_tbl[i].oe;
      gpio_ie   = vec_tbl[i].ie;
      pad_drive = vec_tbl[i].drive;
      #1;
      compare("gpio_io", gpio_pad, vec_tbl[i].exp_pad);
      @(negedge clk);
      // Old pad value still in the last stage
      compare("gpio_in_o", gpio_in, prev_pad & vec_tbl[i].ie);
      @(negedge clk);
      compare("gpio_in_o", gpio_in, vec_tbl[i].exp_in);
      gpio_ie = vec_tbl[i].ie & ~vec_tbl[i].ie_clr;
      #1;
      compare("gpio_in_o", gpio_in, vec_tbl[i].exp_in & ~vec_tbl[i].ie_clr);
      prev_pad = vec_tbl[i].exp_pad;
      mem_access(1'b1, vec_tbl[i].addr, vec_tbl[i].wdata, rdata);
      compare("sram0 cell", i_sram0.peek(vec_tbl[i].addr), vec_tbl[i].wdata[15:0]);
      compare("sram1 cell", i_sram1.peek(vec_tbl[i].addr), vec_tbl[i].wdata[31:16]);
    end

    // ============================================================
    // SRAM read back
    // ============================================================
    for (int i = 0; i < NUM_VEC; i++) begin
      mem_access(1'b0, vec_tbl[i].addr, '0, rdata);
      compare("mem_rdata_o", rdata, vec_tbl[i].wdata);
    end

    $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
    if ((err_cnt == 0) && (tmo_cnt == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* board_top.f */
hw/board_pkg.sv
hw/board_reset_seq.sv
hw/gpio_pad_ring.sv
hw/sram_ctrl.sv
hw/board_top.sv
dv/tb_clk_gen.sv
dv/sram_chip_model.sv
dv/board_tb.sv
